/* test/mem_cases.txt */
// op_addr_wdata_expected_errors_mode; errors: 2 store, 1 load
// mode: 0 plain, 1 random store data, 2 expect last random word, 3 pair with next line
2B_00000010_12345678_00000000_0_0
23_00000010_00000000_12345678_0_0
2B_00000020_11223344_00000000_0_0
28_00000020_123456AA_00000000_0_0
23_00000020_00000000_112233AA_0_0
28_00000021_000000BB_00000000_0_0
23_00000020_00000000_1122BBAA_0_0
28_00000022_000000CC_00000000_0_0
23_00000020_00000000_11CCBBAA_0_0
28_00000023_000000DD_00000000_0_0
23_00000020_00000000_DDCCBBAA_0_0
29_00000030_00008001_00000000_0_0
29_00000032_ABCD9234_00000000_0_0
21_00000030_00000000_FFFF8001_0_0
25_00000030_00000000_00008001_0_0
21_00000032_00000000_FFFF9234_0_0
25_00000032_00000000_00009234_0_0
2B_00000050_80FF017E_00000000_0_0
20_00000050_00000000_0000007E_0_0
24_00000050_00000000_0000007E_0_0
20_00000051_00000000_00000001_0_0
24_00000051_00000000_00000001_0_0
20_00000052_00000000_FFFFFFFF_0_0
24_00000052_00000000_000000FF_0_0
20_00000053_00000000_FFFFFF80_0_0
24_00000053_00000000_00000080_0_0
2B_00000040_00000000_00000000_0_1
2B_00000042_DEADBEEF_00000000_2_0
29_00000041_12345678_00000000_2_0
23_00000040_00000000_00000000_0_2
23_00000046_00000000_00000000_1_0
21_00000041_00000000_00000000_1_0
25_00000043_00000000_00000000_1_0
23_00000010_00000000_12345678_0_3
23_00000020_00000000_DDCCBBAA_0_0
24_00000052_00000000_000000FF_0_3
21_00000032_00000000_FFFF9234_0_0
00_00000010_00000000_00000000_0_0
3F_00000020_00000000_00000000_0_0

/* all.f */
design/mem_pkg.sv
design/mem_control.sv
design/data_ram.sv
design/load_align.sv
design/mem_stage.sv
test/mem_stage_asserts.sv
test/tb_mem_stage.sv

/* Makefile */
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Errors found

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) test/mem_cases.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;

   import mem_pkg::*;

   localparam int MAX_CASES    = 64;
   localparam int WAIT_LIMIT   = 10;
   localparam int QUIET_CYCLES = 3;

   logic              clk;
   logic              rst_n;
   mem_op_e           op_code;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] write_data;
   logic [DATA_W-1:0] load_data;
   logic              load_valid;
   logic              addr_error_sw;
   logic              addr_error_lw;

   // op[111:104] addr[103:72] wdata[71:40] expected[39:8] errors[7:4] mode[3:0]
   logic [111:0]      cases [MAX_CASES];

   integer            seed;
   logic [DATA_W-1:0] last_rand;   // Word written by the last random store
   int                err_count;
   int                case_count;
   int                fail_cases;
   int                idx;
   logic              timed_out;
   logic              ok_a;
   logic              ok_b;

   mem_stage #(
      .ram_depth_words (256)
   ) dut0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .op_code       (op_code),
      .addr          (addr),
      .write_data    (write_data),
      .load_data     (load_data),
      .load_valid    (load_valid),
      .addr_error_sw (addr_error_sw),
      .addr_error_lw (addr_error_lw)
   );

   always #2 clk = ~clk;

   // 0 idle, 1 load, 2 store
   function automatic int classify_op(input logic [7:0] op);
      int kind;
      case (op)
         8'h20, 8'h21, 8'h23, 8'h24, 8'h25: kind = 1;
         8'h28, 8'h29, 8'h2B:               kind = 2;
         default:                           kind = 0;
      endcase
      return kind;
   endfunction

   // ####################
   // Drive and check
   // ####################

   task automatic drive_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] d);
      @(posedge clk);
      op_code    <= mem_op_e'(op[5:0]);
      addr       <= a;
      write_data <= d;
   endtask

   task automatic check_flags(input logic [3:0] err, inout logic ok);
      assert (addr_error_sw === err[1]) else begin
         $display("[ERROR] addr_error_sw got %h expected %h", addr_error_sw, err[1]);
         err_count++;
         ok = 1'b0;
      end
      assert (addr_error_lw === err[0]) else begin
         $display("[ERROR] addr_error_lw got %h expected %h", addr_error_lw, err[0]);
         err_count++;
         ok = 1'b0;
      end
   endtask

   task automatic check_load(input logic [31:0] exp, inout logic ok);
      assert (load_valid === 1'b1) else begin
         $display("[ERROR] load_valid got %h expected 1", load_valid);
         err_count++;
         ok = 1'b0;
      end
      assert (load_data === exp) else begin
         $display("[ERROR] load_data got %h expected %h", load_data, exp);
         err_count++;
         ok = 1'b0;
      end
   endtask

   task automatic wait_result(input logic [31:0] exp, inout logic ok);
      logic got;
      got = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !got; n++) begin
         @(negedge clk);
         got = (load_valid === 1'b1);
      end
      if (got) begin
         check_load(exp, ok);
      end else begin
         $display("Timed out after %0d cycles waiting for load_valid", WAIT_LIMIT);
         timed_out = 1'b1;
         ok = 1'b0;
      end
   endtask

   // Misaligned loads and idle opcodes
   task automatic check_quiet(inout logic ok);
      for (int n = 0; n < QUIET_CYCLES; n++) begin
         @(negedge clk);
         assert (load_valid === 1'b0) else begin
            $display("[ERROR] load_valid got %h expected 0", load_valid);
            err_count++;
            ok = 1'b0;
         end
      end
   endtask

   task automatic run_case(input int i, output logic ok);
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] exp;
      logic [3:0]  err;
      logic [3:0]  mode;
      {op, a, d, exp, err, mode} = cases[i];
      ok = 1'b1;
      if (mode == 4'h1) begin
         d = $random(seed);
         last_rand = d;
      end
      if (mode == 4'h2)
         exp = last_rand;
      drive_op(op, a, d);
      @(negedge clk);
      check_flags(err, ok);
      drive_op(8'h00, '0, '0);   // Store lands on this edge
      if (classify_op(op) == 1 && err == 4'h0)
         wait_result(exp, ok);
      else if (classify_op(op) == 0 || err != 4'h0)
         check_quiet(ok);
   endtask

   // Two loads on consecutive cycles, results one cycle apart
   task automatic run_pair(input int i, output logic ok_first, output logic ok_second);
      logic [111:0] ca;
      logic [111:0] cb;
      ca = cases[i];
      cb = cases[i+1];
      ok_first  = 1'b1;
      ok_second = 1'b1;
      drive_op(ca[111:104], ca[103:72], ca[71:40]);
      @(negedge clk);
      check_flags(ca[7:4], ok_first);
      drive_op(cb[111:104], cb[103:72], cb[71:40]);
      @(negedge clk);
      check_load(ca[39:8], ok_first);
      check_flags(cb[7:4], ok_second);
      drive_op(8'h00, '0, '0);
      @(negedge clk);
      check_load(cb[39:8], ok_second);
   endtask

   task automatic report_case(input int i, input logic ok);
      case_count++;
      if (!ok)
         fail_cases++;
      $display("case %0d op %h addr %h %s", i, cases[i][111:104], cases[i][103:72],
               ok ? "pass" : "FAIL");
   endtask

   // ####################
   // Main sequence
   // ####################

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      op_code    = OP_NOP;
      addr       = '0;
      write_data = '0;
      seed       = 16;
      last_rand  = '0;
      err_count  = 0;
      case_count = 0;
      fail_cases = 0;
      timed_out  = 1'b0;
      for (int k = 0; k < MAX_CASES; k++)
         cases[k] = '1;   // All ones marks an unused entry
      $readmemh("test/mem_cases.txt", cases);

      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      idx = 0;
      while (idx < MAX_CASES && cases[idx] !== '1 && !timed_out) begin
         if (cases[idx][3:0] == 4'h3) begin
            run_pair(idx, ok_a, ok_b);
            report_case(idx, ok_a);
            report_case(idx + 1, ok_b);
            idx += 2;
         end else begin
            run_case(idx, ok_a);
            report_case(idx, ok_a);
            idx++;
         end
      end

      repeat (2) @(posedge clk);
      $display("%0d cases, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
               case_count, case_count - fail_cases, fail_cases, err_count,
               dut0.u_asserts.assert_fails);
      if (err_count == 0 && fail_cases == 0 && !timed_out && case_count > 0 &&
          dut0.u_asserts.assert_fails == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/mem_stage_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage_asserts (
   input wire clk,
   input wire rst_n,
   input wire mem_en,
   input wire load_valid,
   input wire addr_error_sw,
   input wire addr_error_lw
);

   int assert_fails = 0;

   // No result after a cycle without a RAM access
   a_idle_no_valid: assert property (
      @(posedge clk) disable iff (!rst_n) !mem_en |=> !load_valid
   ) else begin
      assert_fails++;
      $error("load_valid high after an idle cycle");
   end

   a_error_no_en: assert property (
      @(posedge clk) disable iff (!rst_n) (addr_error_sw || addr_error_lw) |-> !mem_en
   ) else begin
      assert_fails++;
      $error("mem_en high on a misaligned access");
   end

   a_reset_quiet: assert property (
      @(posedge clk) !rst_n |-> !load_valid
   ) else begin
      assert_fails++;
      $error("load_valid high during reset");
   end

endmodule

bind mem_stage mem_stage_asserts u_asserts (
   .clk           (clk),
   .rst_n         (rst_n),
   .mem_en        (mem_en),
   .load_valid    (load_valid),
   .addr_error_sw (addr_error_sw),
   .addr_error_lw (addr_error_lw)
);

`default_nettype wire

/* design/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
   parameter int ram_depth_words = 256
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire mem_pkg::mem_op_e              op_code,
   input  wire [mem_pkg::ADDR_W-1:0]          addr,
   input  wire [mem_pkg::DATA_W-1:0]          write_data,
   output logic [mem_pkg::DATA_W-1:0]         load_data,
   output logic                               load_valid,
   output logic                               addr_error_sw,
   output logic                               addr_error_lw
);

   import mem_pkg::*;

   // Request side
   logic              mem_en;
   logic [LANES-1:0]  memsel;
   logic [ADDR_W-1:0] final_addr;
   logic [DATA_W-1:0] final_wdata;

   logic [DATA_W-1:0] rd_data;   // RAM to aligner

   // ####################
   // Datapath
   // ####################

   mem_control u_mem_control (
      .op_code       (op_code),
      .addr          (addr),
      .write_data    (write_data),
      .mem_en        (mem_en),
      .memsel        (memsel),
      .final_addr    (final_addr),
      .final_wdata   (final_wdata),
      .addr_error_sw (addr_error_sw),
      .addr_error_lw (addr_error_lw)
   );

   data_ram #(
      .ram_depth_words (ram_depth_words)
   ) u_data_ram (
      .clk     (clk),
      .mem_en  (mem_en),
      .memsel  (memsel),
      .addr    (final_addr),
      .wdata   (final_wdata),
      .rd_data (rd_data)
   );

   // A misaligned load never reaches the aligner since mem_en stays low
   load_align u_load_align (
      .clk        (clk),
      .rst_n      (rst_n),
      .op_code    (op_code),
      .addr_lo    (final_addr[1:0]),
      .rd_en      (mem_en),
      .rd_data    (rd_data),
      .load_data  (load_data),
      .load_valid (load_valid)
   );

endmodule

`default_nettype wire

/* design/load_align.sv */
`timescale 1ns/100ps
`default_nettype none

module load_align (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire mem_pkg::mem_op_e              op_code,
   input  wire [1:0]                          addr_lo,
   input  wire                                rd_en,
   input  wire [mem_pkg::DATA_W-1:0]          rd_data,
   output logic [mem_pkg::DATA_W-1:0]         load_data,
   output logic                               load_valid
);

   import mem_pkg::*;

   logic          take;
   mem_op_e       op_q;
   logic [1:0]    lo_q;
   logic [BYTE_W-1:0] sel_byte;
   logic [HALF_W-1:0] sel_half;

   assign take = rd_en && is_load(op_code);

   // ####################
   // Request capture
   // ####################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         load_valid <= 1'b0;
      else
         load_valid <= take;   // One pulse per accepted load
   end

   always_ff @(posedge clk) begin
      if (take) begin
         op_q <= op_code;
         lo_q <= addr_lo;
      end
   end

   // ####################
   // Lane select and extend
   // ####################

   assign sel_byte = rd_data[lo_q*BYTE_W +: BYTE_W];
   assign sel_half = rd_data[lo_q[1]*HALF_W +: HALF_W];

   always_comb begin
      case (op_q)
         OP_LB:
            load_data = {{(DATA_W-BYTE_W){sel_byte[BYTE_W-1]}}, sel_byte};
         OP_LBU:
            load_data = {{(DATA_W-BYTE_W){1'b0}}, sel_byte};
         OP_LH:
            load_data = {{(DATA_W-HALF_W){sel_half[HALF_W-1]}}, sel_half};
         OP_LHU:
            load_data = {{(DATA_W-HALF_W){1'b0}}, sel_half};
         default:
            load_data = rd_data;   // LW, full word
      endcase
   end

endmodule

`default_nettype wire

/* design/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
   parameter int ram_depth_words = 256
) (
   input  wire                                clk,
   input  wire                                mem_en,
   input  wire [mem_pkg::LANES-1:0]           memsel,
   input  wire [mem_pkg::ADDR_W-1:0]          addr,
   input  wire [mem_pkg::DATA_W-1:0]          wdata,
   output logic [mem_pkg::DATA_W-1:0]         rd_data
);

   import mem_pkg::*;

   localparam int OFS_W = $clog2(LANES);             // Byte offset bits
   localparam int IDX_W = $clog2(ram_depth_words);

   logic [DATA_W-1:0] mem [ram_depth_words];
   logic [IDX_W-1:0]  word_idx;
   logic              wr_cycle;

   assign word_idx = addr[OFS_W +: IDX_W];   // Word part of the address
   assign wr_cycle = mem_en && (memsel != '0);

   // ####################
   // Byte-lane writes
   // ####################

   always_ff @(posedge clk) begin
      if (wr_cycle) begin
         for (int i = 0; i < LANES; i++) begin
            if (memsel[i])
               mem[word_idx][i*BYTE_W +: BYTE_W] <= wdata[i*BYTE_W +: BYTE_W];
         end
      end
   end

   // Registered read, data shows up next cycle
   always_ff @(posedge clk) begin
      if (mem_en && !wr_cycle)
         rd_data <= mem[word_idx];
   end

endmodule

`default_nettype wire

/* design/mem_control.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_control (
   input  wire mem_pkg::mem_op_e              op_code,
   input  wire [mem_pkg::ADDR_W-1:0]          addr,
   input  wire [mem_pkg::DATA_W-1:0]          write_data,
   output logic                               mem_en,
   output logic [mem_pkg::LANES-1:0]          memsel,
   output logic [mem_pkg::ADDR_W-1:0]         final_addr,
   output logic [mem_pkg::DATA_W-1:0]         final_wdata,
   output logic                               addr_error_sw,
   output logic                               addr_error_lw
);

   import mem_pkg::*;

   assign final_addr = addr;   // Address goes through untouched

   // ####################
   // Opcode decode
   // ####################

   always_comb begin
      // Default is an idle cycle
      mem_en        = 1'b0;
      memsel        = '0;
      final_wdata   = '0;
      addr_error_sw = 1'b0;
      addr_error_lw = 1'b0;

      case (op_code)
         OP_SW: begin
            if (addr[1:0] == 2'b00) begin
               mem_en      = 1'b1;
               memsel      = '1;
               final_wdata = write_data;
            end else begin
               addr_error_sw = 1'b1;
            end
         end

         OP_SH: begin
            if (addr[0]) begin
               addr_error_sw = 1'b1;   // Odd half-word address
            end else begin
               mem_en      = 1'b1;
               final_wdata = {2{write_data[HALF_W-1:0]}};
               memsel      = addr[1] ? 4'b1100 : 4'b0011;
            end
         end

         // Bytes are always aligned
         OP_SB: begin
            mem_en              = 1'b1;
            final_wdata         = {LANES{write_data[BYTE_W-1:0]}};
            memsel[addr[1:0]]   = 1'b1;
         end

         OP_LW: begin
            if (addr[1:0] == 2'b00)
               mem_en = 1'b1;   // Read, memsel stays 0
            else
               addr_error_lw = 1'b1;
         end

         OP_LH, OP_LHU: begin
            if (addr[0])
               addr_error_lw = 1'b1;
            else
               mem_en = 1'b1;
         end

         OP_LB, OP_LBU: begin
            mem_en = 1'b1;
         end

         default: begin
            // NOP and unknown opcodes
            mem_en = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

   // ####################
   // Widths
   // ####################

   parameter int DATA_W = 32;
   parameter int ADDR_W = 32;
   parameter int BYTE_W = 8;
   parameter int HALF_W = 16;
   parameter int LANES  = DATA_W / BYTE_W;   // Byte lanes per word

   // ####################
   // Opcodes
   // ####################

   // MIPS primary opcode field
   typedef enum logic [5:0] {
      OP_NOP = 6'h00,
      OP_LB  = 6'h20,
      OP_LH  = 6'h21,
      OP_LW  = 6'h23,
      OP_LBU = 6'h24,
      OP_LHU = 6'h25,
      OP_SB  = 6'h28,
      OP_SH  = 6'h29,
      OP_SW  = 6'h2B
   } mem_op_e;

   // True for the five load opcodes
   function automatic logic is_load(input mem_op_e op);
      logic hit;
      case (op)
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: hit = 1'b1;
         default:                             hit = 1'b0;
      endcase
      return hit;
   endfunction

endpackage

`default_nettype wire
